// File: Makefile
TOP = tb_reg_subsys

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f sim.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "all tests passed" sim.log

clean:
	rm -rf obj_dir sim.log

// File: common/cpu_regs_pkg.sv
// shared types, register code nibbles and command encodings for the register subsystem
package cpu_regs_pkg;

    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  reg_code_t;
    typedef logic [1:0]  rfp_t;

    // high nibble of a register code, banks 0 to 3 are absolute
    localparam logic [3:0] CODE_PREV = 4'hD;
    localparam logic [3:0] CODE_CUR  = 4'hE;
    localparam logic [3:0] CODE_PTR  = 4'hF;

    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_WORD = 2'd1,
        SZ_LONG = 2'd2
    } wr_size_e;

    // value 7 is left unassigned and rejected by the port
    typedef enum logic [2:0] {
        OP_WRITE    = 3'd0,
        OP_READ     = 3'd1,
        OP_RFP_INC  = 3'd2,
        OP_RFP_DEC  = 3'd3,
        OP_RFP_LOAD = 3'd4,
        OP_SP_DEC   = 3'd5,
        OP_IDX      = 3'd6
    } reg_op_e;

    typedef enum logic [1:0] {
        IDX_DISP    = 2'd0,
        IDX_POSTINC = 2'd1,
        IDX_PREDEC  = 2'd2
    } idx_mode_e;

    // command word layout, bits 18:0 of the CMD write
    typedef struct packed {
        logic [2:0] arg;
        logic       rsvd;
        reg_op_e    op;
        idx_mode_e  mode;
        wr_size_e   size;
        reg_code_t  code;
    } reg_cmd_t;

    typedef struct packed {
        logic      en;
        wr_size_e  size;
        reg_code_t code;
        word_t     data;
    } reg_wr_t;

    typedef struct packed {
        logic      inc;
        logic      dec;
        wr_size_e  size;
        reg_code_t code;
    } reg_step_t;

    // byte count of an access size
    function automatic word_t size_step(wr_size_e sz);
        case (sz)
            SZ_BYTE: return 32'd1;
            SZ_WORD: return 32'd2;
            default: return 32'd4;
        endcase
    endfunction

endpackage

// File: design/apb_reg_port.sv
// APB slave with register map, command decode into strobes and error response
module apb_reg_port import cpu_regs_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  word_t             pwdata,
    output word_t             prdata,
    output logic              pready,
    output logic              pslverr,
    output reg_cmd_t          cmd,
    output logic              cmd_valid,
    output reg_wr_t           wr,
    output reg_code_t         rd_code,
    output logic              rfp_inc,
    output logic              rfp_dec,
    output logic              rfp_load,
    output rfp_t              rfp_imm,
    output logic [2:0]        sp_dec,
    output logic [15:0]       disp,
    output byte_t             dmp_addr,
    input  word_t             rd_data,
    input  word_t             xsp,
    input  rfp_t              rfp,
    input  byte_t             dmp_data,
    input  word_t             ea,
    input  logic              ea_valid
);

    localparam logic [ADDR_W-1:0] A_DATA   = ADDR_W'('h400);
    localparam logic [ADDR_W-1:0] A_CMD    = ADDR_W'('h404);
    localparam logic [ADDR_W-1:0] A_XSP    = ADDR_W'('h408);
    localparam logic [ADDR_W-1:0] A_RFP    = ADDR_W'('h40C);
    localparam logic [ADDR_W-1:0] A_RESULT = ADDR_W'('h410);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_DUMP_WAIT
    } state_e;

    state_e state;
    state_e state_nx;
    word_t  data_q;
    word_t  result_q;
    logic   in_dump;
    logic   dump_rd;
    logic   sel_data;
    logic   sel_cmd;
    logic   sel_stat;
    logic   op_ok;
    logic   acc_err;
    logic   xfer_ok;

    // address decode, only long aligned addresses exist
    assign in_dump  = paddr[1:0] == 2'b00 && paddr < A_DATA;
    assign dump_rd  = in_dump && !pwrite;
    assign sel_data = paddr == A_DATA;
    assign sel_cmd  = paddr == A_CMD;
    assign sel_stat = paddr == A_XSP || paddr == A_RFP || paddr == A_RESULT;
    assign cmd      = reg_cmd_t'(pwdata[18:0]);
    assign op_ok    = cmd.op <= OP_IDX;

    always_comb begin
        if (in_dump || sel_stat)
            acc_err = pwrite;
        else if (sel_data)
            acc_err = 1'b0;
        else if (sel_cmd)
            acc_err = !pwrite || !op_ok;
        else
            acc_err = 1'b1;
    end

    always_comb begin
        case (state)
            ST_IDLE:   state_nx = (psel && !penable) ? ST_ACCESS : ST_IDLE;
            // dump data is registered, so hold one extra cycle
            ST_ACCESS: state_nx = dump_rd ? ST_DUMP_WAIT : ST_IDLE;
            default:   state_nx = ST_IDLE;
        endcase
    end

    assign pready    = (state == ST_ACCESS && !dump_rd) || state == ST_DUMP_WAIT;
    assign pslverr   = pready && acc_err;
    assign xfer_ok   = pready && psel && penable && !acc_err;
    assign cmd_valid = xfer_ok && sel_cmd;

    // command strobes
    assign wr = '{
        en:   cmd_valid && cmd.op == OP_WRITE,
        size: cmd.size,
        code: cmd.code,
        data: data_q
    };
    assign rd_code  = cmd.code;
    assign rfp_inc  = cmd_valid && cmd.op == OP_RFP_INC;
    assign rfp_dec  = cmd_valid && cmd.op == OP_RFP_DEC;
    assign rfp_load = cmd_valid && cmd.op == OP_RFP_LOAD;
    assign rfp_imm  = cmd.arg[1:0];
    assign sp_dec   = (cmd_valid && cmd.op == OP_SP_DEC) ? cmd.arg : 3'd0;
    assign disp     = data_q[15:0];
    assign dmp_addr = paddr[9:2];

    always_comb begin
        prdata = '0;
        if (state == ST_DUMP_WAIT)
            prdata = {24'd0, dmp_data};
        else if (sel_data)
            prdata = data_q;
        else if (paddr == A_XSP)
            prdata = xsp;
        else if (paddr == A_RFP)
            prdata = {30'd0, rfp};
        else if (paddr == A_RESULT)
            prdata = result_q;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            result_q <= '0;
        end else begin
            state <= state_nx;
            // address arrives one cycle after its OP_IDX
            if (ea_valid)
                result_q <= ea;
            else if (cmd_valid && cmd.op == OP_READ)
                result_q <= rd_data;
        end
    end

    always_ff @(posedge clk) begin
        if (xfer_ok && sel_data && pwrite)
            data_q <= pwdata;
    end

    a_penable_after_psel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel && $past(psel))
        else $error("penable without a preceding setup phase");

endmodule

// File: design/idx_addr.sv
// indexed effective address generator with pointer update requests
module idx_addr import cpu_regs_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_cmd_t    cmd,
    input  logic        cmd_valid,
    input  logic [15:0] disp,
    input  word_t       ptr_data,
    output reg_step_t   step,
    output word_t       ea,
    output logic        ea_valid
);

    logic  is_idx;
    word_t stride;
    word_t ea_next;

    assign is_idx = cmd_valid && cmd.op == OP_IDX;
    assign stride = size_step(cmd.size);

    always_comb begin
        case (cmd.mode)
            // old pointer is the address
            IDX_POSTINC: ea_next = ptr_data;
            // address equals the new pointer
            IDX_PREDEC:  ea_next = ptr_data - stride;
            default:     ea_next = ptr_data + {{16{disp[15]}}, disp};
        endcase
    end

    // pointer update lands on the same edge as the address
    assign step = '{
        inc:  is_idx && cmd.mode == IDX_POSTINC,
        dec:  is_idx && cmd.mode == IDX_PREDEC,
        size: cmd.size,
        code: cmd.code
    };

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ea_valid <= 1'b0;
        end else begin
            ea_valid <= is_idx;
        end
    end

    always_ff @(posedge clk) begin
        if (is_idx)
            ea <= ea_next;
    end

    a_idx_ptr_code: assert property (@(posedge clk) disable iff (rst)
        is_idx |-> cmd.code[7:4] == CODE_PTR)
        else $error("indexed command on a non-pointer register code");

endmodule

// File: design/reg_subsys_top.sv
// register subsystem top level joining the APB port, address generator and register file
module reg_subsys_top import cpu_regs_pkg::*; #(
    parameter int ADDR_W = 12
) (
    input  logic              clk,
    input  logic              rst,
    input  logic [ADDR_W-1:0] paddr,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  word_t             pwdata,
    output word_t             prdata,
    output logic              pready,
    output logic              pslverr
);

    reg_cmd_t    cmd;
    logic        cmd_valid;
    reg_wr_t     wr;
    reg_code_t   rd_code;
    logic        rfp_inc;
    logic        rfp_dec;
    logic        rfp_load;
    rfp_t        rfp_imm;
    logic [2:0]  sp_dec;
    logic [15:0] disp;
    byte_t       dmp_addr;
    word_t       rd_data;
    word_t       ptr_data;
    word_t       xsp;
    rfp_t        rfp;
    byte_t       dmp_data;
    reg_step_t   step;
    word_t       ea;
    logic        ea_valid;

    apb_reg_port #(
        .ADDR_W (ADDR_W)
    ) u_port (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .wr       (wr),
        .rd_code  (rd_code),
        .rfp_inc  (rfp_inc),
        .rfp_dec  (rfp_dec),
        .rfp_load (rfp_load),
        .rfp_imm  (rfp_imm),
        .sp_dec   (sp_dec),
        .disp     (disp),
        .dmp_addr (dmp_addr),
        .rd_data  (rd_data),
        .xsp      (xsp),
        .rfp      (rfp),
        .dmp_data (dmp_data),
        .ea       (ea),
        .ea_valid (ea_valid)
    );

    idx_addr u_idx (
        .clk      (clk),
        .rst      (rst),
        .cmd      (cmd),
        .cmd_valid(cmd_valid),
        .disp     (disp),
        .ptr_data (ptr_data),
        .step     (step),
        .ea       (ea),
        .ea_valid (ea_valid)
    );

    cpu_regs u_regs (
        .clk      (clk),
        .rst      (rst),
        .wr       (wr),
        .step     (step),
        .rd_code  (rd_code),
        .rfp_inc  (rfp_inc),
        .rfp_dec  (rfp_dec),
        .rfp_load (rfp_load),
        .rfp_imm  (rfp_imm),
        .sp_dec   (sp_dec),
        .dmp_addr (dmp_addr),
        .rd_data  (rd_data),
        .ptr_data (ptr_data),
        .xsp      (xsp),
        .rfp      (rfp),
        .dmp_data (dmp_data)
    );

endmodule

// File: regfile/cpu_regs.sv
// banked accumulator and pointer register file with bank pointer, stack decrement and dump port
module cpu_regs import cpu_regs_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  reg_wr_t    wr,
    input  reg_step_t  step,
    input  reg_code_t  rd_code,
    input  logic       rfp_inc,
    input  logic       rfp_dec,
    input  logic       rfp_load,
    input  rfp_t       rfp_imm,
    input  logic [2:0] sp_dec,
    input  byte_t      dmp_addr,
    output word_t      rd_data,
    output word_t      ptr_data,
    output word_t      xsp,
    output rfp_t       rfp,
    output byte_t      dmp_data
);

    // four banks of sixteen bytes
    byte_t accs [0:63];
    // XIX, XIY, XIZ, XSP, little endian
    byte_t ptrs [0:15];

    reg_code_t  rd_sel;
    reg_code_t  wr_sel;
    logic       wr_acc;
    logic       wr_ptr;
    logic [3:0] lane_we;
    word_t      lane_data;
    logic       step_ptr;
    word_t      ptr_next;
    word_t      xsp_next;

    // map current and previous bank codes onto an absolute bank
    function automatic reg_code_t resolve(reg_code_t c, rfp_t bp);
        reg_code_t r;
        r = c;
        if (c[7:4] == CODE_CUR)
            r[7:4] = {2'b00, bp};
        else if (c[7:4] == CODE_PREV)
            r[7:4] = {2'b00, bp - 2'd1};
        return r;
    endfunction

    assign rd_sel   = resolve(rd_code, rfp);
    assign wr_sel   = resolve(wr.code, rfp);
    assign wr_acc   = wr_sel[7:6] == 2'b00;
    assign wr_ptr   = wr_sel[7:4] == CODE_PTR;
    assign step_ptr = step.code[7:4] == CODE_PTR;
    assign xsp      = {ptrs[15], ptrs[14], ptrs[13], ptrs[12]};
    assign xsp_next = xsp - word_t'(sp_dec);
    assign ptr_next = step.dec ? ptr_data - size_step(step.size)
                               : ptr_data + size_step(step.size);

    // aligned long holding the code, banks 4 to C read zero
    always_comb begin
        rd_data = '0;
        for (int i = 0; i < 4; i++) begin
            if (rd_sel[7:6] == 2'b00)
                rd_data[8*i +: 8] = accs[{rd_sel[5:2], 2'(i)}];
            else if (rd_sel[7:4] == CODE_PTR)
                rd_data[8*i +: 8] = ptrs[{rd_sel[3:2], 2'(i)}];
        end
    end

    // pointer seen by the address generator
    always_comb begin
        for (int i = 0; i < 4; i++)
            ptr_data[8*i +: 8] = ptrs[{step.code[3:2], 2'(i)}];
    end

    // byte lanes of the aligned long touched by a sized write
    always_comb begin
        case (wr.size)
            SZ_BYTE: begin
                lane_we   = 4'b0001 << wr_sel[1:0];
                lane_data = {4{wr.data[7:0]}};
            end
            SZ_WORD: begin
                lane_we   = wr_sel[1] ? 4'b1100 : 4'b0011;
                lane_data = {2{wr.data[15:0]}};
            end
            SZ_LONG: begin
                lane_we   = 4'b1111;
                lane_data = wr.data;
            end
            default: begin
                lane_we   = 4'b0000;
                lane_data = wr.data;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 64; i++)
                accs[i] <= '0;
            for (int i = 0; i < 16; i++)
                ptrs[i] <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr.en && lane_we[i] && wr_acc)
                    accs[{wr_sel[5:2], 2'(i)}] <= lane_data[8*i +: 8];
                if (wr.en && lane_we[i] && wr_ptr)
                    ptrs[{wr_sel[3:2], 2'(i)}] <= lane_data[8*i +: 8];
                // post-increment or pre-decrement update
                if (step_ptr && (step.inc || step.dec))
                    ptrs[{step.code[3:2], 2'(i)}] <= ptr_next[8*i +: 8];
                if (sp_dec != 3'd0)
                    ptrs[{2'd3, 2'(i)}] <= xsp_next[8*i +: 8];
            end
        end
    end

    // bank pointer wraps modulo 4
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rfp <= '0;
        end else if (rfp_load) begin
            rfp <= rfp_imm;
        end else if (rfp_inc) begin
            rfp <= rfp + 2'd1;
        end else if (rfp_dec) begin
            rfp <= rfp - 2'd1;
        end
    end

    // registered dump, one cycle after the index
    always_ff @(posedge clk) begin
        if (dmp_addr < 8'h40)
            dmp_data <= accs[dmp_addr[5:0]];
        else if (dmp_addr < 8'h50)
            dmp_data <= ptrs[dmp_addr[3:0]];
        else
            dmp_data <= '0;
    end

    a_rfp_single_op: assert property (@(posedge clk) disable iff (rst)
        $onehot0({rfp_inc, rfp_dec, rfp_load}))
        else $error("more than one bank pointer operation in a cycle");

    a_word_even: assert property (@(posedge clk) disable iff (rst)
        wr.en && wr.size == SZ_WORD |-> !wr.code[0])
        else $error("word write to an odd register code");

    a_wr_step_apart: assert property (@(posedge clk) disable iff (rst)
        wr.en && (step.inc || step.dec) |-> wr_sel[7:2] != step.code[7:2])
        else $error("write and pointer step hit the same register");

endmodule

// File: sim.f
+incdir+sim
common/cpu_regs_pkg.sv
regfile/cpu_regs.sv
design/idx_addr.sv
design/apb_reg_port.sv
design/reg_subsys_top.sv
sim/tb_reg_subsys.sv

// File: sim/reg_model.svh
// reference model of the register subsystem cells, bank pointer and command effects
`ifndef REG_MODEL_SVH
`define REG_MODEL_SVH

// cells 0 to 63 are accumulators, 64 to 79 the pointer bytes
byte_t m_cell [0:79];
rfp_t  m_rfp;
word_t m_result;
word_t m_data;

function automatic void reset_shadow();
    for (int i = 0; i < 80; i++)
        m_cell[i] = '0;
    m_rfp    = '0;
    m_result = '0;
    m_data   = '0;
endfunction

function automatic int byte_count(int size);
    if (size == 0)
        return 1;
    else if (size == 1)
        return 2;
    return 4;
endfunction

// cell of a register code, -1 for the empty banks 4 to C
function automatic int cell_index(reg_code_t c);
    if (c[7:4] == 4'hF)
        return 64 + int'(c[3:0]);
    if (c[7:4] == 4'hE)
        return 16 * int'(m_rfp) + int'(c[3:0]);
    if (c[7:4] == 4'hD)
        return 16 * ((int'(m_rfp) + 3) % 4) + int'(c[3:0]);
    if (c[7:4] < 4'h4)
        return 16 * int'(c[7:4]) + int'(c[3:0]);
    return -1;
endfunction

function automatic word_t read_long(reg_code_t c);
    int    base;
    word_t v;
    base = cell_index(c);
    v = '0;
    if (base >= 0) begin
        base = base - base % 4;
        for (int i = 0; i < 4; i++)
            v[8*i +: 8] = m_cell[base + i];
    end
    return v;
endfunction

// little endian, the low byte lands at the aligned code
function automatic void write_cells(reg_code_t c, int size, word_t d);
    int base;
    int n;
    n = byte_count(size);
    base = cell_index(c);
    if (base >= 0) begin
        base = base - base % n;
        for (int i = 0; i < n; i++)
            m_cell[base + i] = d[8*i +: 8];
    end
endfunction

function automatic void apply_cmd(reg_op_e op, reg_code_t c, int size, int mode, int arg);
    word_t p;
    word_t stride;
    p = read_long(c);
    stride = word_t'(byte_count(size));
    case (op)
        OP_WRITE:    write_cells(c, size, m_data);
        OP_READ:     m_result = p;
        OP_RFP_INC:  m_rfp = m_rfp + 2'd1;
        OP_RFP_DEC:  m_rfp = m_rfp - 2'd1;
        OP_RFP_LOAD: m_rfp = rfp_t'(arg);
        OP_SP_DEC:   write_cells(8'hFC, 2, read_long(8'hFC) - word_t'(arg));
        OP_IDX: begin
            if (mode == 0) begin
                m_result = p + {{16{m_data[15]}}, m_data[15:0]};
            end else if (mode == 1) begin
                m_result = p;
                write_cells(c, 2, p + stride);
            end else begin
                m_result = p - stride;
                write_cells(c, 2, m_result);
            end
        end
        default: ;
    endcase
endfunction

`endif

// File: sim/tb_reg_subsys.sv
// testbench driving the register subsystem over APB against a reference model
module tb_reg_subsys import cpu_regs_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int          ADDR_W      = 12;
    localparam int          ACK_TIMEOUT = 20;
    localparam logic [11:0] A_DATA      = 12'h400;
    localparam logic [11:0] A_CMD       = 12'h404;
    localparam logic [11:0] A_XSP       = 12'h408;
    localparam logic [11:0] A_RFP       = 12'h40C;
    localparam logic [11:0] A_RESULT    = 12'h410;

    logic              clk;
    logic              rst;
    logic [ADDR_W-1:0] paddr;
    logic              psel;
    logic              penable;
    logic              pwrite;
    word_t             pwdata;
    word_t             prdata;
    logic              pready;
    logic              pslverr;

    string test_name;
    string name_q [$];
    word_t exp_q [$];
    word_t act_q [$];
    int    checks;
    int    errors;
    int    checks_mark;
    int    errors_mark;

    `include "reg_model.svh"

    reg_subsys_top #(
        .ADDR_W (ADDR_W)
    ) u_dut (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // drain pending compares, each counted before it leaves the queue
    always @(posedge clk) begin : compare_proc
        while (act_q.size() != 0) begin
            checks++;
            assert (act_q[0] === exp_q[0])
            else begin
                $display("** Error %s: expected %h, actual %h", name_q[0], exp_q[0], act_q[0]);
                errors++;
            end
            name_q.delete(0);
            exp_q.delete(0);
            act_q.delete(0);
        end
    end

    task automatic expect_val(string what, word_t exp, word_t act);
        name_q.push_back({test_name, " ", what});
        exp_q.push_back(exp);
        act_q.push_back(act);
    endtask

    // one APB transfer with a setup phase and an access phase until pready
    task automatic apb_xfer(input logic [11:0] addr, input logic wr, input word_t wdata,
                            output word_t rdata, output logic err, output int waits);
        int cycles;
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= wr;
        pwdata  <= wdata;
        psel    <= 1'b1;
        penable <= 1'b0;
        @(posedge clk);
        penable <= 1'b1;
        @(posedge clk);
        cycles = 0;
        while (!pready && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (!pready) begin
            $display("no pready within %0d cycles at address %h", ACK_TIMEOUT, addr);
            $display("tests failed");
            $finish;
        end else begin
            rdata   = prdata;
            err     = pslverr;
            waits   = cycles;
            psel    <= 1'b0;
            penable <= 1'b0;
        end
    endtask

    task automatic write_reg(logic [11:0] addr, word_t data);
        word_t rd;
        logic  err;
        int    waits;
        apb_xfer(addr, 1'b1, data, rd, err, waits);
        expect_val($sformatf("pslverr on write %h", addr), 32'd0, {31'd0, err});
        expect_val($sformatf("wait states on write %h", addr), 32'd0, word_t'(waits));
    endtask

    task automatic read_and_check(string what, logic [11:0] addr, word_t exp);
        word_t rd;
        logic  err;
        int    waits;
        apb_xfer(addr, 1'b0, '0, rd, err, waits);
        expect_val(what, exp, rd);
        expect_val({what, " pslverr"}, 32'd0, {31'd0, err});
        // dump reads take one wait state for the registered cell
        expect_val({what, " wait states"}, addr < A_DATA ? 32'd1 : 32'd0, word_t'(waits));
    endtask

    task automatic load_data(word_t data);
        write_reg(A_DATA, data);
        m_data = data;
    endtask

    // command word fields at bits 7:0, 9:8, 11:10, 14:12 and 18:16
    task automatic send_cmd(reg_op_e op, reg_code_t code, int size, int mode, int arg);
        word_t w;
        w = '0;
        w[7:0]   = code;
        w[9:8]   = size[1:0];
        w[11:10] = mode[1:0];
        w[14:12] = op;
        w[18:16] = arg[2:0];
        write_reg(A_CMD, w);
        apply_cmd(op, code, size, mode, arg);
    endtask

    task automatic expect_illegal(logic [11:0] addr, logic wr, word_t data);
        word_t rd;
        logic  err;
        int    waits;
        apb_xfer(addr, wr, data, rd, err, waits);
        expect_val($sformatf("pslverr at %h", addr), 32'd1, {31'd0, err});
    endtask

    task automatic dump_and_check(int first, int last);
        for (int idx = first; idx <= last; idx++)
            read_and_check($sformatf("dump %02h", idx), 12'(idx * 4),
                           {24'd0, idx < 80 ? m_cell[idx] : 8'h00});
    endtask

    task automatic check_status();
        read_and_check("rfp", A_RFP, {30'd0, m_rfp});
        read_and_check("xsp", A_XSP, read_long(8'hFC));
        read_and_check("result", A_RESULT, m_result);
    endtask

    function automatic reg_code_t pick_code(logic [3:0] hi, int size);
        reg_code_t c;
        c = {hi, 4'($urandom_range(15, 0))};
        if (size == 1)
            c[0] = 1'b0;
        else if (size == 2)
            c[1:0] = 2'b00;
        return c;
    endfunction

    task automatic report_test();
        int cycles;
        cycles = 0;
        while (act_q.size() != 0 && cycles < ACK_TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (act_q.size() != 0) begin
            $display("compare queue did not drain in test %s", test_name);
            $display("tests failed");
            $finish;
        end else begin
            $display("%s: %0d checks, %0d errors", test_name, checks - checks_mark,
                     errors - errors_mark);
            checks_mark = checks;
            errors_mark = errors;
        end
    endtask

    initial begin
        int        size;
        reg_code_t code;
        void'($urandom(32'hf575788d));
        rst     = 1'b1;
        paddr   = '0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = '0;
        reset_shadow();
        repeat (16) @(posedge clk);
        rst <= 1'b0;

        test_name = "reset";
        dump_and_check(0, 255);
        check_status();
        report_test();

        test_name = "abs_writes";
        for (int n = 0; n < 24; n++) begin
            size = int'($urandom_range(2, 0));
            code = pick_code(4'($urandom_range(3, 0)), size);
            load_data($urandom());
            send_cmd(OP_WRITE, code, size, 0, 0);
            send_cmd(OP_READ, {code[7:2], 2'($urandom_range(3, 0))}, 0, 0, 0);
            read_and_check("read result", A_RESULT, m_result);
        end
        // empty bank reads back zero
        send_cmd(OP_READ, 8'h40, 0, 0, 0);
        read_and_check("bank 4 result", A_RESULT, m_result);
        dump_and_check(0, 63);
        report_test();

        test_name = "bank_ptr";
        send_cmd(OP_RFP_LOAD, 8'h00, 0, 0, int'($urandom_range(7, 0)));
        read_and_check("rfp load", A_RFP, {30'd0, m_rfp});
        repeat (5) begin
            send_cmd(OP_RFP_INC, 8'h00, 0, 0, 0);
            read_and_check("rfp inc", A_RFP, {30'd0, m_rfp});
        end
        repeat (6) begin
            send_cmd(OP_RFP_DEC, 8'h00, 0, 0, 0);
            read_and_check("rfp dec", A_RFP, {30'd0, m_rfp});
        end
        for (int n = 0; n < 8; n++) begin
            send_cmd(OP_RFP_LOAD, 8'h00, 0, 0, int'($urandom_range(3, 0)));
            size = int'($urandom_range(2, 0));
            load_data($urandom());
            send_cmd(OP_WRITE, pick_code(4'hE, size), size, 0, 0);
            size = int'($urandom_range(2, 0));
            load_data($urandom());
            send_cmd(OP_WRITE, pick_code(4'hD, size), size, 0, 0);
            send_cmd(OP_READ, pick_code(4'hE, 0), 0, 0, 0);
            read_and_check("current bank result", A_RESULT, m_result);
        end
        dump_and_check(0, 63);
        report_test();

        test_name = "sp_dec";
        load_data($urandom());
        send_cmd(OP_WRITE, 8'hFC, 2, 0, 0);
        repeat (8) begin
            send_cmd(OP_SP_DEC, 8'h00, 0, 0, int'($urandom_range(7, 1)));
            read_and_check("xsp", A_XSP, read_long(8'hFC));
        end
        report_test();

        test_name = "indexed";
        for (int p = 0; p < 3; p++) begin
            load_data($urandom());
            send_cmd(OP_WRITE, {4'hF, 2'(p), 2'b00}, 2, 0, 0);
        end
        for (int mode = 0; mode < 3; mode++) begin
            for (int sz = 0; sz < 3; sz++) begin
                code = {4'hF, 2'($urandom_range(2, 0)), 2'b00};
                load_data($urandom());
                send_cmd(OP_IDX, code, sz, mode, 0);
                read_and_check($sformatf("ea mode %0d size %0d", mode, sz), A_RESULT, m_result);
                send_cmd(OP_READ, code, 0, 0, 0);
                read_and_check($sformatf("ptr mode %0d size %0d", mode, sz), A_RESULT, m_result);
            end
        end
        report_test();

        test_name = "illegal";
        expect_illegal(12'h000, 1'b1, $urandom());
        expect_illegal(12'h0FC, 1'b1, $urandom());
        expect_illegal(12'h3FC, 1'b1, $urandom());
        expect_illegal(A_CMD, 1'b0, '0);
        expect_illegal(A_XSP, 1'b1, $urandom());
        expect_illegal(A_RFP, 1'b1, 32'd3);
        expect_illegal(A_RESULT, 1'b1, $urandom());
        expect_illegal(12'h414, 1'b0, '0);
        expect_illegal(12'h414, 1'b1, $urandom());
        expect_illegal(12'hFFC, 1'b0, '0);
        // op 7 with a write to code 00
        expect_illegal(A_CMD, 1'b1, 32'h0000_7000);
        dump_and_check(0, 255);
        check_status();
        read_and_check("data", A_DATA, m_data);
        report_test();

        $display("summary: 6 tests, %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule
